// ==== mips_tu.f ====
hw/mips_cp0_pkg.sv
hw/tlb_pkg.sv
hw/direct_map_xlate.sv
hw/tlb_lookup.sv
hw/tlb_array.sv
hw/translation_unit.sv
test/translation_unit_assertions.sv
test/tb_translation_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_translation_unit \
    -f mips_tu.f \
    -o sim_translation_unit \
    || { echo "verilator build failed"; exit 1; }

result=$(./obj_dir/sim_translation_unit 2>&1)
echo "$result"
echo "$result" | grep -qx '>>> PASS' && exit 0 || exit 1

// ==== test/tb_translation_unit.sv ====
module tb_translation_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_entries  = 16;
    localparam int idx_w      = $clog2(n_entries);
    localparam int clk_period = 4;
    localparam int n_written  = 12; // the top entries stay as reset left them.

    // test lengths in cycles.
    localparam int reset_cycles     = 2;
    localparam int cleared_cycles   = 8;
    localparam int direct_cycles    = 32;
    localparam int translate_cycles = 200;
    localparam int overlap_writes   = 3;
    localparam int overlap_cycles   = 100;
    localparam int total_cycles     = reset_cycles + cleared_cycles + direct_cycles +
                                      n_written + translate_cycles + overlap_writes +
                                      overlap_cycles;
    localparam int margin_cycles    = 40;

    logic        clk;
    logic        resetn;
    logic        i_k0_uncached;
    logic [31:0] i_inst_vaddr;
    logic [31:0] i_data_vaddr;
    logic        i_data_store;
    logic        i_tlbwi;
    logic [31:0] i_index;
    logic [31:0] i_entryhi;
    logic [31:0] i_entrylo0;
    logic [31:0] i_entrylo1;
    logic [31:0] o_inst_paddr;
    logic        o_inst_uncached;
    logic [31:0] o_data_paddr;
    logic        o_data_uncached;
    logic        o_inst_refill;
    logic        o_inst_invalid;
    logic        o_data_refill;
    logic        o_data_invalid;
    logic        o_data_modified;
    logic [31:0] o_entryhi;
    logic [31:0] o_entrylo0;
    logic [31:0] o_entrylo1;
    logic [31:0] o_index;

    // shadow TLB kept in the CP0 word formats as written.
    logic [31:0] shadow_hi  [n_entries];
    logic [31:0] shadow_lo0 [n_entries];
    logic [31:0] shadow_lo1 [n_entries];

    string test_name;
    logic  checking;
    int    checks;
    int    xlate_errors;
    int    flag_errors;
    int    cp0_errors;

    translation_unit #(
        .n_entries(n_entries)
    ) dut0 (
        .clk(clk), .resetn(resetn), .i_k0_uncached(i_k0_uncached),
        .i_inst_vaddr(i_inst_vaddr), .i_data_vaddr(i_data_vaddr),
        .i_data_store(i_data_store), .i_tlbwi(i_tlbwi), .i_index(i_index),
        .i_entryhi(i_entryhi), .i_entrylo0(i_entrylo0), .i_entrylo1(i_entrylo1),
        .o_inst_paddr(o_inst_paddr), .o_inst_uncached(o_inst_uncached),
        .o_data_paddr(o_data_paddr), .o_data_uncached(o_data_uncached),
        .o_inst_refill(o_inst_refill), .o_inst_invalid(o_inst_invalid),
        .o_data_refill(o_data_refill), .o_data_invalid(o_data_invalid),
        .o_data_modified(o_data_modified), .o_entryhi(o_entryhi),
        .o_entrylo0(o_entrylo0), .o_entrylo1(o_entrylo1), .o_index(o_index)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < n_entries; i++) begin
                shadow_hi[i]  <= '0;
                shadow_lo0[i] <= '0;
                shadow_lo1[i] <= '0;
            end
        end else if (i_tlbwi) begin
            shadow_hi[i_index[idx_w-1:0]]  <= i_entryhi;
            shadow_lo0[i_index[idx_w-1:0]] <= i_entrylo0;
            shadow_lo1[i_index[idx_w-1:0]] <= i_entrylo1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model.
    //////////////////////////////////////////////////////////////////////

    // lowest entry whose vpn2 matches and whose asid matches or which is global.
    function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] asid);
        int   found;
        logic is_global;
        found = -1;
        for (int i = 0; i < n_entries; i++) begin
            is_global = shadow_lo0[i][0] & shadow_lo1[i][0];
            if (found < 0 && shadow_hi[i][31:13] == vpn2 &&
                    (shadow_hi[i][7:0] == asid || is_global)) begin
                found = i;
            end
        end
        return found;
    endfunction

    // packs {paddr, uncached, refill, invalid, modified}.
    function automatic logic [35:0] expect_xlate(input logic [31:0] vaddr,
            input logic store, input logic k0_unc, input logic [7:0] asid);
        logic [31:0] lo;
        logic [31:0] paddr;
        logic        uncached;
        logic        refill;
        logic        invalid;
        logic        modified;
        int          hit;
        paddr    = '0;
        uncached = 1'b0;
        refill   = 1'b0;
        invalid  = 1'b0;
        modified = 1'b0;
        if (vaddr[31:30] == 2'b10) begin
            paddr    = {3'b000, vaddr[28:0]};
            uncached = vaddr[29] | k0_unc; // bit 29 tells kseg1 from kseg0.
        end else begin
            hit = find_entry(vaddr[31:13], asid);
            if (hit < 0) begin
                refill = 1'b1;
            end else begin
                lo       = vaddr[12] ? shadow_lo1[hit] : shadow_lo0[hit];
                paddr    = {lo[25:6], vaddr[11:0]};
                uncached = (lo[5:3] == 3'd2);
                invalid  = ~lo[1];
                modified = lo[1] & ~lo[2] & store;
            end
        end
        return {paddr, uncached, refill, invalid, modified};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Comparison in the middle of each cycle.
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
    endtask

    task automatic check_outputs();
        logic [35:0] inst_exp;
        logic [35:0] data_exp;
        logic [31:0] hi_exp;
        logic [31:0] lo0_exp;
        logic [31:0] lo1_exp;
        logic [31:0] index_exp;
        logic        g_exp;
        int          rd;
        int          probe;
        inst_exp  = expect_xlate(i_inst_vaddr, 1'b0, i_k0_uncached, i_entryhi[7:0]);
        data_exp  = expect_xlate(i_data_vaddr, i_data_store, i_k0_uncached, i_entryhi[7:0]);
        rd        = int'(i_index[idx_w-1:0]);
        g_exp     = shadow_lo0[rd][0] & shadow_lo1[rd][0];
        hi_exp    = {shadow_hi[rd][31:13], 5'd0, shadow_hi[rd][7:0]};
        lo0_exp   = {6'd0, shadow_lo0[rd][25:1], g_exp};
        lo1_exp   = {6'd0, shadow_lo1[rd][25:1], g_exp};
        probe     = find_entry(i_entryhi[31:13], i_entryhi[7:0]);
        index_exp = (probe < 0) ? 32'h8000_0000 : 32'(probe);
        checks++;
        // paddr and C are don't-care on a refill.
        if (!inst_exp[2] && o_inst_paddr !== inst_exp[35:4]) begin
            report_mismatch("inst_paddr", inst_exp[35:4], o_inst_paddr);
            xlate_errors++;
        end
        if (!inst_exp[2] && o_inst_uncached !== inst_exp[3]) begin
            report_mismatch("inst_uncached", {31'd0, inst_exp[3]}, {31'd0, o_inst_uncached});
            xlate_errors++;
        end
        if (!data_exp[2] && o_data_paddr !== data_exp[35:4]) begin
            report_mismatch("data_paddr", data_exp[35:4], o_data_paddr);
            xlate_errors++;
        end
        if (!data_exp[2] && o_data_uncached !== data_exp[3]) begin
            report_mismatch("data_uncached", {31'd0, data_exp[3]}, {31'd0, o_data_uncached});
            xlate_errors++;
        end
        if ({o_inst_refill, o_inst_invalid} !== inst_exp[2:1]) begin
            report_mismatch("inst_flags", {30'd0, inst_exp[2:1]},
                            {30'd0, o_inst_refill, o_inst_invalid});
            flag_errors++;
        end
        if ({o_data_refill, o_data_invalid, o_data_modified} !== data_exp[2:0]) begin
            report_mismatch("data_flags", {29'd0, data_exp[2:0]},
                            {29'd0, o_data_refill, o_data_invalid, o_data_modified});
            flag_errors++;
        end
        if (o_entryhi !== hi_exp) begin
            report_mismatch("tlbr_entryhi", hi_exp, o_entryhi);
            cp0_errors++;
        end
        if (o_entrylo0 !== lo0_exp) begin
            report_mismatch("tlbr_entrylo0", lo0_exp, o_entrylo0);
            cp0_errors++;
        end
        if (o_entrylo1 !== lo1_exp) begin
            report_mismatch("tlbr_entrylo1", lo1_exp, o_entrylo1);
            cp0_errors++;
        end
        if (o_index !== index_exp) begin
            report_mismatch("tlbp_index", index_exp, o_index);
            cp0_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (checking) check_outputs();
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // a kuseg or kseg2/kseg3 address.
    function automatic logic [31:0] mapped_addr();
        logic [31:0] r;
        r = $urandom();
        if (r[31:30] == 2'b10) r[31] = 1'b0;
        return r;
    endfunction

    task automatic write_entry(input int idx, input logic [31:0] hi,
            input logic [31:0] lo0, input logic [31:0] lo1);
        i_tlbwi    = 1'b1;
        i_index    = 32'(idx);
        i_entryhi  = hi;
        i_entrylo0 = lo0;
        i_entrylo1 = lo1;
        next_cycle();
        i_tlbwi    = 1'b0;
    endtask

    // favored, when not negative, is picked for half of the page hits.
    task automatic drive_lookup(input int favored);
        logic [31:0] r;
        logic [31:0] r2;
        int          k;
        r  = $urandom();
        r2 = $urandom();
        k  = (favored >= 0 && r[0]) ? favored : int'($urandom_range(0, n_entries - 1));
        i_inst_vaddr = (r[2:1] != 2'b00) ? {shadow_hi[k][31:13], r[15:3]} : mapped_addr();
        k  = (favored >= 0 && r2[0]) ? favored : int'($urandom_range(0, n_entries - 1));
        i_data_vaddr = (r2[2:1] != 2'b00) ? {shadow_hi[k][31:13], r2[15:3]} : mapped_addr();
        k  = int'($urandom_range(0, n_entries - 1));
        i_entryhi = {r[16] ? shadow_hi[k][31:13] : r2[31:13], r[21:17],
                     8'($urandom_range(1, 3))};
        i_index       = 32'($urandom_range(0, n_entries - 1));
        i_data_store  = r[22];
        i_k0_uncached = r[23];
        next_cycle();
    endtask

    initial begin
        logic [31:0] r;
        void'($urandom(32'hf30f));
        resetn        = 1'b0;
        checking      = 1'b0;
        checks        = 0;
        xlate_errors  = 0;
        flag_errors   = 0;
        cp0_errors    = 0;
        test_name     = "reset";
        i_k0_uncached = 1'b0;
        i_inst_vaddr  = '0;
        i_data_vaddr  = '0;
        i_data_store  = 1'b0;
        i_tlbwi       = 1'b0;
        i_index       = '0;
        i_entryhi     = '0;
        i_entrylo0    = '0;
        i_entrylo1    = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        resetn   = 1'b1;
        checking = 1'b1;

        test_name = "cleared_tlb";
        for (int n = 0; n < cleared_cycles; n++) begin
            r = $urandom();
            i_inst_vaddr = {19'd0, r[12:0]}; // vpn2 0 lands on the cleared entry 0.
            i_data_vaddr = mapped_addr();
            i_data_store = r[13];
            i_entryhi    = {31'd0, r[14]};
            next_cycle();
        end

        test_name = "direct_map";
        for (int n = 0; n < direct_cycles; n++) begin
            r = $urandom();
            i_inst_vaddr  = {2'b10, r[29:0]};
            r = $urandom();
            i_data_vaddr  = {2'b10, r[29:0]};
            i_data_store  = r[30];
            i_k0_uncached = r[31];
            i_index       = 32'($urandom_range(0, n_entries - 1));
            next_cycle();
        end

        // each vpn2 carries its index, so the written pages are distinct.
        test_name = "tlbwi";
        for (int k = 0; k < n_written; k++) begin
            r = $urandom();
            write_entry(k, {r[18], r[18], r[12:0], 4'(k), r[17:13], 8'($urandom_range(1, 3))},
                        $urandom(), $urandom());
        end

        test_name = "tlb_translate";
        repeat (translate_cycles) drive_lookup(-1);

        // a global entry 1 shadows entry 9, and entry 5 is written twice in a row.
        test_name = "overlap";
        write_entry(1, {shadow_hi[9][31:13], 5'd0, 8'($urandom_range(1, 3))},
                    $urandom() | 32'd1, $urandom() | 32'd1);
        write_entry(5, mapped_addr(), $urandom(), $urandom());
        write_entry(5, mapped_addr(), $urandom(), $urandom());
        repeat (overlap_cycles) drive_lookup(9);

        checking = 1'b0;
        $display("checks %0d, translation errors %0d, flag errors %0d, cp0 errors %0d",
                 checks, xlate_errors, flag_errors, cp0_errors);
        if (xlate_errors + flag_errors + cp0_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((total_cycles + margin_cycles) * clk_period);
        $display("watchdog expired: the tests did not finish within %0d cycles",
                 total_cycles + margin_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== test/translation_unit_assertions.sv ====
module translation_unit_assertions (
    input logic        clk,
    input logic        resetn,
    input logic [31:0] i_inst_vaddr,
    input logic [31:0] i_data_vaddr,
    input logic        i_data_store,
    input logic        i_inst_refill,
    input logic        i_inst_invalid,
    input logic        i_data_refill,
    input logic        i_data_invalid,
    input logic        i_data_modified
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////////////////////////
    // Exception flag rules.
    //////////////////////////////////////////////////////////////////////

    a_inst_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(i_inst_refill && i_inst_invalid))
        else $error("inst refill and inst invalid are high together");

    a_data_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(i_data_refill && i_data_invalid))
        else $error("data refill and data invalid are high together");

    // kseg0 and kseg1 never go through the TLB.
    a_inst_unmapped: assert property (@(posedge clk) disable iff (!resetn)
        (i_inst_vaddr[31:30] == 2'b10) |-> !(i_inst_refill || i_inst_invalid))
        else $error("inst flag raised on an unmapped address");

    a_data_unmapped: assert property (@(posedge clk) disable iff (!resetn)
        (i_data_vaddr[31:30] == 2'b10) |->
            !(i_data_refill || i_data_invalid || i_data_modified))
        else $error("data flag raised on an unmapped address");

    a_modified_store: assert property (@(posedge clk) disable iff (!resetn)
        i_data_modified |-> i_data_store)
        else $error("modified raised on a data load");

endmodule

bind translation_unit translation_unit_assertions asserts0 (
    .clk            (clk),
    .resetn         (resetn),
    .i_inst_vaddr   (i_inst_vaddr),
    .i_data_vaddr   (i_data_vaddr),
    .i_data_store   (i_data_store),
    .i_inst_refill  (o_inst_refill),
    .i_inst_invalid (o_inst_invalid),
    .i_data_refill  (o_data_refill),
    .i_data_invalid (o_data_invalid),
    .i_data_modified(o_data_modified)
);

// ==== hw/translation_unit.sv ====
module translation_unit #(
    parameter int n_entries = 16
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        i_k0_uncached,

    input  logic [31:0] i_inst_vaddr,
    input  logic [31:0] i_data_vaddr,
    input  logic        i_data_store,

    input  logic        i_tlbwi,
    input  logic [31:0] i_index,
    input  logic [31:0] i_entryhi,
    input  logic [31:0] i_entrylo0,
    input  logic [31:0] i_entrylo1,

    output logic [31:0] o_inst_paddr,
    output logic        o_inst_uncached,
    output logic [31:0] o_data_paddr,
    output logic        o_data_uncached,

    output logic        o_inst_refill,
    output logic        o_inst_invalid,
    output logic        o_data_refill,
    output logic        o_data_invalid,
    output logic        o_data_modified,

    output logic [31:0] o_entryhi,
    output logic [31:0] o_entrylo0,
    output logic [31:0] o_entrylo1,
    output logic [31:0] o_index
);

    localparam int idx_w = $clog2(n_entries);

    mips_cp0_pkg::va_word_u     probe_word;
    mips_cp0_pkg::cp0_index_t   index_w;
    mips_cp0_pkg::cp0_entrylo_t lo0_w;
    mips_cp0_pkg::cp0_entrylo_t lo1_w;
    mips_cp0_pkg::cp0_entryhi_t hi_r;
    mips_cp0_pkg::cp0_entrylo_t lo0_r;
    mips_cp0_pkg::cp0_entrylo_t lo1_r;
    mips_cp0_pkg::cp0_index_t   index_r;
    tlb_pkg::tlb_entry_t        wentry;
    tlb_pkg::tlb_entry_t        rentry;
    tlb_pkg::tlb_hit_t          inst_hit;
    tlb_pkg::tlb_hit_t          data_hit;
    tlb_pkg::tlb_hit_t          probe_hit;

    logic        inst_mapped;
    logic        data_mapped;
    logic [31:0] inst_direct_paddr;
    logic [31:0] data_direct_paddr;
    logic        inst_direct_uncached;
    logic        data_direct_uncached;

    //////////////////////////////////////////////////////////////////////
    // CP0 word packing for TLBWI and unpacking for TLBR and TLBP.
    //////////////////////////////////////////////////////////////////////

    assign probe_word = i_entryhi; // read as EntryHi here, as an address by the probe.
    assign index_w    = i_index;
    assign lo0_w      = i_entrylo0;
    assign lo1_w      = i_entrylo1;

    always_comb begin
        wentry.vpn2 = probe_word.entryhi.vpn2;
        wentry.asid = probe_word.entryhi.asid;
        wentry.g    = lo0_w.g & lo1_w.g; // an entry is global only if both halves say so.
        wentry.pfn0 = lo0_w.pfn;
        wentry.c0   = lo0_w.c;
        wentry.d0   = lo0_w.d;
        wentry.v0   = lo0_w.v;
        wentry.pfn1 = lo1_w.pfn;
        wentry.c1   = lo1_w.c;
        wentry.d1   = lo1_w.d;
        wentry.v1   = lo1_w.v;
    end

    assign hi_r    = '{vpn2: rentry.vpn2, zero: '0, asid: rentry.asid};
    assign lo0_r   = '{fill: '0, pfn: rentry.pfn0, c: rentry.c0, d: rentry.d0,
                       v: rentry.v0, g: rentry.g};
    assign lo1_r   = '{fill: '0, pfn: rentry.pfn1, c: rentry.c1, d: rentry.d1,
                       v: rentry.v1, g: rentry.g};
    assign index_r = '{p: ~probe_hit.hit, zero: '0, index: probe_hit.index};

    assign o_entryhi  = hi_r;
    assign o_entrylo0 = lo0_r;
    assign o_entrylo1 = lo1_r;
    assign o_index    = index_r;

    //////////////////////////////////////////////////////////////////////
    // Direct and TLB translation.
    //////////////////////////////////////////////////////////////////////

    direct_map_xlate inst_direct (
        .i_vaddr      (i_inst_vaddr),
        .i_k0_uncached(i_k0_uncached),
        .o_mapped     (inst_mapped),
        .o_paddr      (inst_direct_paddr),
        .o_uncached   (inst_direct_uncached)
    );

    direct_map_xlate data_direct (
        .i_vaddr      (i_data_vaddr),
        .i_k0_uncached(i_k0_uncached),
        .o_mapped     (data_mapped),
        .o_paddr      (data_direct_paddr),
        .o_uncached   (data_direct_uncached)
    );

    tlb_array #(
        .n_entries(n_entries)
    ) tlb (
        .clk         (clk),
        .resetn      (resetn),
        .i_we        (i_tlbwi),
        .i_waddr     (index_w.index[idx_w-1:0]),
        .i_wentry    (wentry),
        .i_raddr     (index_w.index[idx_w-1:0]),
        .o_rentry    (rentry),
        .i_inst_vaddr(i_inst_vaddr),
        .i_data_vaddr(i_data_vaddr),
        .i_probe     (probe_word),
        .i_asid      (probe_word.entryhi.asid),
        .o_inst_hit  (inst_hit),
        .o_data_hit  (data_hit),
        .o_probe_hit (probe_hit)
    );

    assign o_inst_paddr    = inst_mapped ? inst_hit.paddr : inst_direct_paddr;
    assign o_data_paddr    = data_mapped ? data_hit.paddr : data_direct_paddr;
    assign o_inst_uncached = inst_mapped ? (inst_hit.cattr == tlb_pkg::C_UNCACHED)
                                         : inst_direct_uncached;
    assign o_data_uncached = data_mapped ? (data_hit.cattr == tlb_pkg::C_UNCACHED)
                                         : data_direct_uncached;

    // Exceptions only arise on mapped addresses.
    assign o_inst_refill   = inst_mapped & ~inst_hit.hit;
    assign o_inst_invalid  = inst_mapped & inst_hit.hit & ~inst_hit.valid;
    assign o_data_refill   = data_mapped & ~data_hit.hit;
    assign o_data_invalid  = data_mapped & data_hit.hit & ~data_hit.valid;
    assign o_data_modified = data_mapped & data_hit.hit & data_hit.valid &
                             ~data_hit.dirty & i_data_store; // loads never fault on D.

endmodule

// ==== hw/tlb_array.sv ====
module tlb_array #(
    parameter int n_entries = 16
) (
    input  logic                          clk,
    input  logic                          resetn,

    // TLBWI write port.
    input  logic                          i_we,
    input  logic [$clog2(n_entries)-1:0]  i_waddr,
    input  tlb_pkg::tlb_entry_t           i_wentry,

    // TLBR read port.
    input  logic [$clog2(n_entries)-1:0]  i_raddr,
    output tlb_pkg::tlb_entry_t           o_rentry,

    // lookups.
    input  logic [31:0]                   i_inst_vaddr,
    input  logic [31:0]                   i_data_vaddr,
    input  mips_cp0_pkg::va_word_u        i_probe,
    input  logic [7:0]                    i_asid,
    output tlb_pkg::tlb_hit_t             o_inst_hit,
    output tlb_pkg::tlb_hit_t             o_data_hit,
    output tlb_pkg::tlb_hit_t             o_probe_hit
);

    tlb_pkg::tlb_entry_t [n_entries-1:0] entries;

    //////////////////////////////////////////////////////////////////////
    // Entry storage.
    //////////////////////////////////////////////////////////////////////

    // After reset every entry is zero, so vpn2 0 with asid 0 hits an invalid entry 0.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            entries <= '0;
        end else if (i_we) begin
            entries[i_waddr] <= i_wentry; // visible to all lookups next cycle.
        end
    end

    assign o_rentry = entries[i_raddr];

    //////////////////////////////////////////////////////////////////////
    // One table, three independent lookups.
    //////////////////////////////////////////////////////////////////////

    tlb_lookup #(
        .n_entries(n_entries)
    ) inst_lookup (
        .i_entries(entries),
        .i_vaddr  (i_inst_vaddr),
        .i_asid   (i_asid),
        .o_hit    (o_inst_hit)
    );

    tlb_lookup #(
        .n_entries(n_entries)
    ) data_lookup (
        .i_entries(entries),
        .i_vaddr  (i_data_vaddr),
        .i_asid   (i_asid),
        .o_hit    (o_data_hit)
    );

    // the probe uses only hit and index of the result.
    tlb_lookup #(
        .n_entries(n_entries)
    ) probe_lookup (
        .i_entries(entries),
        .i_vaddr  (i_probe),
        .i_asid   (i_asid),
        .o_hit    (o_probe_hit)
    );

endmodule

// ==== hw/tlb_lookup.sv ====
module tlb_lookup #(
    parameter int n_entries = 16
) (
    input  tlb_pkg::tlb_entry_t [n_entries-1:0] i_entries,
    input  mips_cp0_pkg::va_word_u              i_vaddr,
    input  logic [7:0]                          i_asid,
    output tlb_pkg::tlb_hit_t                   o_hit
);

    localparam int idx_w = $clog2(n_entries);

    logic [n_entries-1:0] match;
    logic [idx_w-1:0]     hit_idx;
    tlb_pkg::tlb_entry_t  sel;

    //////////////////////////////////////////////////////////////////////
    // Associative compare against every entry.
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < n_entries; i++) begin : g_match
        assign match[i] = (i_entries[i].vpn2 == i_vaddr.va.vpn2) &&
                          ((i_entries[i].asid == i_asid) || i_entries[i].g);
    end

    // scan from the top so that the lowest matching index is left in hit_idx.
    always_comb begin
        hit_idx = '0;
        for (int i = n_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = idx_w'(i);
            end
        end
    end

    assign sel = i_entries[hit_idx];

    //////////////////////////////////////////////////////////////////////
    // Even/odd page selection.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_hit = '0;
        o_hit.hit = |match;
        o_hit.index[idx_w-1:0] = hit_idx; // upper index bits stay zero.
        if (i_vaddr.va.odd) begin
            o_hit.paddr = {sel.pfn1, i_vaddr.va.offset};
            o_hit.valid = sel.v1;
            o_hit.dirty = sel.d1;
            o_hit.cattr = sel.c1;
        end else begin
            o_hit.paddr = {sel.pfn0, i_vaddr.va.offset};
            o_hit.valid = sel.v0;
            o_hit.dirty = sel.d0;
            o_hit.cattr = sel.c0;
        end
    end

endmodule

// ==== hw/direct_map_xlate.sv ====
module direct_map_xlate (
    input  logic [31:0] i_vaddr,
    input  logic        i_k0_uncached,
    output logic        o_mapped,
    output logic [31:0] o_paddr,
    output logic        o_uncached
);

    logic is_kseg0;
    logic is_kseg1;

    // kseg0 and kseg1 share the top two bits 10 and bypass the TLB.
    assign o_mapped = (i_vaddr[31:30] != mips_cp0_pkg::KSEG0_BASE[31:30]);

    assign is_kseg0 = (i_vaddr[31:29] == mips_cp0_pkg::KSEG0_BASE[31:29]);
    assign is_kseg1 = (i_vaddr[31:29] == mips_cp0_pkg::KSEG1_BASE[31:29]);

    // Both unmapped segments alias the same physical window.
    assign o_paddr = i_vaddr & mips_cp0_pkg::PHYS_MASK;

    assign o_uncached = is_kseg1 | (is_kseg0 & i_k0_uncached); // K0 follows Config.

endmodule

// ==== hw/tlb_pkg.sv ====
package tlb_pkg;

    //////////////////////////////////////////////////////////////////////
    // TLB storage and lookup formats.
    //////////////////////////////////////////////////////////////////////

    // C field value that marks a mapped page as uncached.
    localparam logic [2:0] C_UNCACHED = 3'd2;

    // one joint TLB entry holds an even/odd page pair.
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;     // global entries ignore the asid.
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    // Result of one associative lookup.
    // The index is sized for 32 entries and smaller TLBs use the low bits.
    typedef struct packed {
        logic [31:0] paddr;
        logic        hit;
        logic        valid; // V of the selected page.
        logic        dirty; // D of the selected page.
        logic [2:0]  cattr;
        logic [4:0]  index;
    } tlb_hit_t;

endpackage

// ==== hw/mips_cp0_pkg.sv ====
package mips_cp0_pkg;

    //////////////////////////////////////////////////////////////////////
    // Segment map of the 32-bit virtual address space.
    //////////////////////////////////////////////////////////////////////

    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000; // cached, unmapped.
    localparam logic [31:0] KSEG1_BASE = 32'ha000_0000; // uncached, unmapped.
    localparam logic [31:0] PHYS_MASK  = 32'h1fff_ffff; // both segments see the low 512 MB.

    //////////////////////////////////////////////////////////////////////
    // CP0 register formats used by TLBWI, TLBR and TLBP.
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [18:0] vpn2;  // virtual page pair number.
        logic [4:0]  zero;
        logic [7:0]  asid;
    } cp0_entryhi_t;

    typedef struct packed {
        logic [5:0]  fill;
        logic [19:0] pfn;
        logic [2:0]  c;     // cache attribute.
        logic        d;     // writes allowed.
        logic        v;
        logic        g;
    } cp0_entrylo_t;

    // index is sized for the largest legal TLB of 32 entries.
    typedef struct packed {
        logic        p;     // set when the probe found no match.
        logic [25:0] zero;
        logic [4:0]  index;
    } cp0_index_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;   // selects the odd page of the pair.
        logic [11:0] offset;
    } cp0_vaddr_t;

    // TLBP presents EntryHi to a lookup as if it were an address.
    typedef union packed {
        cp0_vaddr_t   va;
        cp0_entryhi_t entryhi;
    } va_word_u;

endpackage
